//--- common/md_defines.svh
`ifndef MD_DEFINES_SVH
`define MD_DEFINES_SVH

////////////////////////////////////////////////////////////
// Lane and cell organisation
////////////////////////////////////////////////////////////
`define NUM_LANES 8                // Filter lanes
`define SLOTS_PER_LANE 2           // Cell memories owned by each lane
`define SLOT_W 4                   // 16 cell slots
`define CELL_ADDR_W 8              // Word 0 count, words 1 and up particles
`define MAX_CELL_PARTICLES 220

////////////////////////////////////////////////////////////
// Arithmetic widths
////////////////////////////////////////////////////////////
// Signed fixed point, 4 fraction bits per coordinate
`define POS_W 16
// Three squared 17 bit differences
`define DIST2_W 34
// Cutoff of 12.0 squared, 8 fraction bits after squaring
`define CUTOFF_2 (144 * 256)

// Accepted pairs buffered per lane
`define FIFO_DEPTH 4

`endif

//--- common/md_pkg.sv
`default_nettype none

`include "md_defines.svh"

package md_pkg;

	// One particle position, x in the top bits
	typedef struct packed {
		logic signed [`POS_W-1:0] x;
		logic signed [`POS_W-1:0] y;
		logic signed [`POS_W-1:0] z;
	} pos_t;

	// Cell slot plus address inside the cell
	typedef struct packed {
		logic [`SLOT_W-1:0] slot;
		logic [`CELL_ADDR_W-1:0] addr;
	} particle_id_t;

	// Layout of word 0 of a cell
	typedef struct packed {
		logic [3*`POS_W-`CELL_ADDR_W-1:0] pad;    // Zero filled
		logic [`CELL_ADDR_W-1:0] count;           // Particles in this cell
	} count_word_t;

	// Count in word 0, positions in all other words
	typedef union packed {
		pos_t pos;
		count_word_t cnt;
	} cell_word_u;

	// Reference particle broadcast to the lanes
	typedef struct packed {
		particle_id_t id;
		pos_t pos;
	} ref_t;

	// One accepted pair
	typedef struct packed {
		particle_id_t ref_id;
		particle_id_t nb_id;
		logic [`DIST2_W-1:0] dist2;
	} pair_t;

endpackage

`default_nettype wire

//--- source/cell_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module cell_memory #(
	parameter int SLOT = 0                       // Slot number this memory answers to
) (
	input  logic clk,
	input  logic load_en,
	input  logic [`SLOT_W-1:0] load_slot,
	input  logic [`CELL_ADDR_W-1:0] load_addr,
	input  md_pkg::cell_word_u load_word,
	input  logic [`CELL_ADDR_W-1:0] rd_addr,
	output md_pkg::cell_word_u rd_word
);
	import md_pkg::*;

	localparam logic [`SLOT_W-1:0] MY_SLOT = `SLOT_W'(SLOT);

	// Word 0 holds the count, then one word per particle
	cell_word_u mem [0:`MAX_CELL_PARTICLES];

	logic wr_hit;

	// Load bus is shared by all cells, only a slot match writes
	assign wr_hit = load_en && (load_slot == MY_SLOT);

	always_ff @(posedge clk)
	begin
		if (wr_hit)
		begin
			mem[load_addr] <= load_word;
		end
		rd_word <= mem[rd_addr];                  // Data one cycle after address
	end

endmodule

`default_nettype wire

//--- source/ref_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module ref_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic load_en,
	input  logic [`SLOT_W-1:0] load_slot,
	input  logic [`CELL_ADDR_W-1:0] load_addr,
	input  md_pkg::cell_word_u load_word,
	input  logic [`NUM_LANES-1:0] lane_done,
	input  logic all_empty,
	output logic ref_valid,
	output md_pkg::ref_t ref_particle,
	output logic done
);
	import md_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ_COUNT,
		S_READ_REF,
		S_BCAST,
		S_WAIT_LANES,
		S_WAIT_DRAIN,
		S_DONE
	} seq_state_t;

	seq_state_t state;
	logic [`CELL_ADDR_W-1:0] home_count;         // Particles in the home cell
	logic [`CELL_ADDR_W-1:0] ref_addr;           // Current reference, from 1
	logic ref_phase;                             // Second cycle of the reference read
	logic [`CELL_ADDR_W-1:0] rd_addr;
	cell_word_u rd_word;
	pos_t ref_pos;

	// Home cell copy, slot 0
	cell_memory #(
		.SLOT(0)
	) i_home_cell (
		.clk(clk),
		.load_en(load_en),
		.load_slot(load_slot),
		.load_addr(load_addr),
		.load_word(load_word),
		.rd_addr(rd_addr),
		.rd_word(rd_word)
	);

	// Parked on the count word except while fetching a reference
	assign rd_addr = (state == S_READ_REF) ? ref_addr : '0;

	assign ref_valid = (state == S_BCAST);
	assign done = (state == S_DONE);
	assign ref_particle = '{id: '{slot: '0, addr: ref_addr}, pos: ref_pos};

	////////////////////////////////////////////////////////////
	// Reference loop
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			home_count <= '0;
			ref_addr <= '0;
			ref_phase <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (start)
						state <= S_READ_COUNT;
				S_READ_COUNT:                      // Count word read during the start cycle
				begin
					home_count <= rd_word.cnt.count;
					ref_addr <= `CELL_ADDR_W'(1);
					ref_phase <= 1'b0;
					// Empty home cell has nothing to broadcast
					state <= (rd_word.cnt.count == '0) ? S_WAIT_DRAIN : S_READ_REF;
				end
				S_READ_REF:
				begin
					ref_phase <= ~ref_phase;
					if (ref_phase)
						state <= S_BCAST;
				end
				S_BCAST:
					state <= S_WAIT_LANES;
				S_WAIT_LANES:
					if (&lane_done)
					begin
						if (ref_addr >= home_count)   // Last reference walked
							state <= S_WAIT_DRAIN;
						else
						begin
							ref_addr <= ref_addr + 1'b1;
							state <= S_READ_REF;
						end
					end
				S_WAIT_DRAIN:
					if (all_empty)                 // Lane buffers drained into the arbiter
						state <= S_DONE;
				default:
					state <= S_IDLE;               // Done lasts one cycle
			endcase
		end
	end

	// Reference position, captured on the second read cycle
	always_ff @(posedge clk)
	begin
		if (state == S_READ_REF && ref_phase)
			ref_pos <= rd_word.pos;
	end

endmodule

`default_nettype wire

//--- neighbor_lane/pair_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module pair_fifo (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  md_pkg::pair_t push_pair,
	input  logic pop,
	output md_pkg::pair_t head,
	output logic empty,
	output logic full
);
	import md_pkg::*;

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	pair_t entries [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0] count;                       // Occupancy, 0 to depth
	logic do_push, do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign head = entries[rd_ptr];               // Head visible without a read cycle
	assign empty = (count == '0);
	assign full = (count == (PTR_W + 1)'(`FIFO_DEPTH));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;       // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			entries[wr_ptr] <= push_pair;
	end

endmodule

`default_nettype wire

//--- neighbor_lane/neighbor_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module neighbor_lane #(
	parameter int LANE = 0
) (
	input  logic clk,
	input  logic rst,
	input  logic load_en,
	input  logic [`SLOT_W-1:0] load_slot,
	input  logic [`CELL_ADDR_W-1:0] load_addr,
	input  md_pkg::cell_word_u load_word,
	input  logic ref_valid,
	input  md_pkg::ref_t ref_particle,
	output logic lane_done,
	input  logic pop,
	output md_pkg::pair_t fifo_pair,
	output logic fifo_empty
);
	import md_pkg::*;

	// Lanes 0 and 1 pair their live cell with a spare slot
	localparam bit TWO_CELLS = (LANE >= 2);
	localparam logic [`SLOT_W-1:0] BASE_SLOT = `SLOT_W'(`SLOTS_PER_LANE * LANE);

	typedef enum logic [1:0] {L_IDLE, L_COUNT, L_WALK, L_FLUSH} lane_state_t;

	lane_state_t state;
	ref_t ref_q;
	logic sel;                                   // Cell being walked
	logic [`CELL_ADDR_W-1:0] addr;               // Next neighbour address to read
	logic [`CELL_ADDR_W-1:0] cell_count;
	cell_word_u rd_word [`SLOTS_PER_LANE];
	logic stall;
	logic push;
	logic fifo_full;
	// Stage 1 holds the memory word in flight
	logic s1_valid;
	logic s1_sel;
	logic [`CELL_ADDR_W-1:0] s1_addr;
	particle_id_t nb_id;
	pos_t nb_pos;
	logic signed [`POS_W:0] dx;
	logic signed [`POS_W:0] dy;
	logic signed [`POS_W:0] dz;
	logic [`DIST2_W-1:0] dist2;
	logic keep;
	// Stage 2 holds the registered distance
	logic s2_valid;
	pair_t s2_pair;

	function automatic logic [`DIST2_W-1:0] square(input logic signed [`POS_W:0] d);
		logic signed [`DIST2_W-1:0] p;
		p = d * d;
		return p;
	endfunction

	////////////////////////////////////////////////////////////
	// Cell memories with address replay while stalled
	////////////////////////////////////////////////////////////
	for (genvar k = 0; k < `SLOTS_PER_LANE; k++)
	begin : g_cell
		logic [`CELL_ADDR_W-1:0] rd_addr;
		logic [`CELL_ADDR_W-1:0] rd_addr_q;

		// Idle cell sits on its count word
		assign rd_addr = stall ? rd_addr_q : ((sel == k) ? addr : '0);

		always_ff @(posedge clk)
		begin
			if (rst)
				rd_addr_q <= '0;
			else
				rd_addr_q <= rd_addr;              // Repeat last read so data holds
		end

		cell_memory #(
			.SLOT(`SLOTS_PER_LANE * LANE + k)
		) i_cell (
			.clk(clk),
			.load_en(load_en),
			.load_slot(load_slot),
			.load_addr(load_addr),
			.load_word(load_word),
			.rd_addr(rd_addr),
			.rd_word(rd_word[k])
		);
	end

	assign stall = fifo_full && (state != L_IDLE);  // Full buffer freezes the walk
	assign push = s2_valid && !fifo_full;

	// Squared distance and cutoff filter
	assign nb_pos = rd_word[s1_sel].pos;
	assign nb_id = '{slot: BASE_SLOT + `SLOT_W'(s1_sel), addr: s1_addr};
	assign dx = nb_pos.x - ref_q.pos.x;
	assign dy = nb_pos.y - ref_q.pos.y;
	assign dz = nb_pos.z - ref_q.pos.z;
	assign dist2 = square(dx) + square(dy) + square(dz);
	// Home cell pairs kept once and never self
	assign keep = (dist2 < `CUTOFF_2) &&
		((nb_id.slot != ref_q.id.slot) || (s1_addr > ref_q.id.addr));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= L_IDLE;
			sel <= 1'b0;
			addr <= '0;
			cell_count <= '0;
			s1_valid <= 1'b0;
			s1_sel <= 1'b0;
			s1_addr <= '0;
			s2_valid <= 1'b0;
			lane_done <= 1'b0;
		end
		else if (!stall)
		begin
			s2_valid <= s1_valid && keep;
			s1_valid <= 1'b0;
			case (state)
				L_IDLE:
					if (ref_valid)
					begin
						lane_done <= 1'b0;
						state <= L_COUNT;
					end
				L_COUNT:
				begin
					cell_count <= rd_word[sel].cnt.count;
					addr <= `CELL_ADDR_W'(1);
					state <= L_WALK;
				end
				L_WALK:
					if (addr <= cell_count)        // Issue one neighbour read
					begin
						s1_valid <= 1'b1;
						s1_sel <= sel;
						s1_addr <= addr;
						addr <= addr + 1'b1;
					end
					else if (TWO_CELLS && !sel)
					begin
						sel <= 1'b1;                // Second cell count already parked
						addr <= '0;
						state <= L_COUNT;
					end
					else
						state <= L_FLUSH;
				default:                           // Stage 2 pushes its last pair here
				begin
					sel <= 1'b0;
					addr <= '0;
					lane_done <= 1'b1;
					state <= L_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == L_IDLE && ref_valid)
			ref_q <= ref_particle;
		if (!stall)
			s2_pair <= '{ref_id: ref_q.id, nb_id: nb_id, dist2: dist2};
	end

	pair_fifo i_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_pair(s2_pair),
		.pop(pop),
		.head(fifo_pair),
		.empty(fifo_empty),
		.full(fifo_full)
	);

endmodule

`default_nettype wire

//--- source/pair_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module pair_arbiter (
	input  logic clk,
	input  logic rst,
	input  md_pkg::pair_t fifo_pair [`NUM_LANES],
	input  logic [`NUM_LANES-1:0] fifo_empty,
	output logic [`NUM_LANES-1:0] pop,
	output logic pair_valid,
	output md_pkg::pair_t pair,
	output logic all_empty
);

	localparam int LANE_W = $clog2(`NUM_LANES);

	logic [LANE_W-1:0] last;                     // Lane served most recently
	logic [LANE_W-1:0] pick;
	logic found;

	////////////////////////////////////////////////////////////
	// Rotating priority search
	////////////////////////////////////////////////////////////
	always_comb
	begin
		int idx;
		found = 1'b0;
		pick = last;
		// Start one past the last winner and wrap
		for (int k = 1; k <= `NUM_LANES; k++)
		begin
			idx = (int'(last) + k) % `NUM_LANES;
			if (!found && !fifo_empty[idx])
			begin
				found = 1'b1;
				pick = LANE_W'(idx);
			end
		end
	end

	assign pop = found ? (`NUM_LANES'(1) << pick) : '0;  // Takes the head this cycle
	assign all_empty = &fifo_empty;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			last <= LANE_W'(`NUM_LANES - 1);         // Lane 0 wins first
			pair_valid <= 1'b0;
		end
		else
		begin
			pair_valid <= found;
			if (found)
				last <= pick;
		end
	end

	// Output pair register
	always_ff @(posedge clk)
	begin
		if (found)
			pair <= fifo_pair[pick];
	end

endmodule

`default_nettype wire

//--- source/pair_gen_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module pair_gen_top (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic load_en,
	input  logic [`SLOT_W-1:0] load_slot,
	input  logic [`CELL_ADDR_W-1:0] load_addr,
	input  md_pkg::cell_word_u load_word,
	output logic pair_valid,
	output md_pkg::pair_t pair,
	output logic done
);
	import md_pkg::*;

	// Reference broadcast
	logic ref_valid;
	ref_t ref_particle;
	logic [`NUM_LANES-1:0] lane_done;
	// Lane buffers to the arbiter
	pair_t fifo_pair [`NUM_LANES];
	logic [`NUM_LANES-1:0] fifo_empty;
	logic [`NUM_LANES-1:0] pop;
	logic all_empty;

	ref_sequencer i_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.load_en(load_en),
		.load_slot(load_slot),
		.load_addr(load_addr),
		.load_word(load_word),
		.lane_done(lane_done),
		.all_empty(all_empty),
		.ref_valid(ref_valid),
		.ref_particle(ref_particle),
		.done(done)
	);

	// Lane i walks slots 2i and 2i+1
	for (genvar i = 0; i < `NUM_LANES; i++)
	begin : g_lane
		neighbor_lane #(
			.LANE(i)
		) i_lane (
			.clk(clk),
			.rst(rst),
			.load_en(load_en),
			.load_slot(load_slot),
			.load_addr(load_addr),
			.load_word(load_word),
			.ref_valid(ref_valid),
			.ref_particle(ref_particle),
			.lane_done(lane_done[i]),
			.pop(pop[i]),
			.fifo_pair(fifo_pair[i]),
			.fifo_empty(fifo_empty[i])
		);
	end

	pair_arbiter i_arb (
		.clk(clk),
		.rst(rst),
		.fifo_pair(fifo_pair),
		.fifo_empty(fifo_empty),
		.pop(pop),
		.pair_valid(pair_valid),
		.pair(pair),
		.all_empty(all_empty)
	);

endmodule

`default_nettype wire

//--- bench/pair_gen_cases.svh
`ifndef PAIR_GEN_CASES_SVH
`define PAIR_GEN_CASES_SVH

localparam int NUM_CASES = 8;
localparam int TAB_COLS = 18;
localparam int SPAN_COL = 16;                    // Coordinates drawn from -span to +span
localparam int DELAY_COL = 17;                   // Idle cycles between loading and start

////////////////////////////////////////////////////////////
// Case table
////////////////////////////////////////////////////////////
// Columns 0 to 15 hold the particle count of each slot
// Column 16 the coordinate span, column 17 the idle cycles before start
localparam int CASE_TAB [NUM_CASES][TAB_COLS] = '{
	// Mixed small cells, medium span
	'{6, 0, 3, 0, 2, 4, 1, 0, 5, 3, 2, 2, 4, 1, 3, 2, 200, 2},
	// Sparse, most pairs beyond cutoff
	'{8, 0, 10, 0, 9, 10, 8, 12, 10, 7, 11, 10, 9, 10, 8, 10, 600, 0},
	// Tight span, every pair kept so lane buffers fill
	'{10, 0, 12, 0, 12, 12, 12, 12, 12, 12, 12, 12, 12, 12, 12, 12, 40, 3},
	// Empty home cell
	'{0, 0, 5, 0, 4, 6, 5, 3, 2, 5, 4, 4, 3, 6, 5, 2, 100, 1},
	// Spare slots loaded with particles that must never pair
	'{5, 7, 3, 9, 3, 3, 3, 3, 3, 3, 3, 3, 3, 3, 3, 3, 50, 2},
	// Large home cell, some lanes with an empty first or second cell
	'{40, 0, 4, 0, 6, 3, 0, 8, 5, 2, 7, 4, 0, 6, 3, 5, 250, 4},
	// One full cell
	'{3, 0, 2, 0, 2, 2, 2, 2, 2, 220, 2, 2, 2, 2, 2, 2, 120, 0},
	// Lone home particle, no neighbours at all
	'{1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 100, 1}
};

`endif

//--- bench/pair_gen_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "md_defines.svh"

module pair_gen_tb;
	import md_pkg::*;

	`include "pair_gen_cases.svh"

	localparam int NUM_SLOTS = 1 << `SLOT_W;
	localparam int DRIVE_DELAY = 10;             // After the rising edge
	localparam int TAIL_CYCLES = 5;              // Quiet window after done

	logic clk;
	logic rst;
	logic start;
	logic load_en;
	logic [`SLOT_W-1:0] load_slot;
	logic [`CELL_ADDR_W-1:0] load_addr;
	cell_word_u load_word;
	logic pair_valid;
	pair_t pair;
	logic done;

	// Testbench copy of every cell
	pos_t cell_pos [NUM_SLOTS][`MAX_CELL_PARTICLES+1];
	bit exp_set [int];                           // Pairs the model keeps
	bit seen_set [int];                          // Pairs already received
	int exp_total;
	int pairs_seen;
	int done_seen;
	bit collecting;                              // Between start and next load

	pair_gen_top i_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.load_en(load_en),
		.load_slot(load_slot),
		.load_addr(load_addr),
		.load_word(load_word),
		.pair_valid(pair_valid),
		.pair(pair),
		.done(done)
	);

	always #50 clk = ~clk;                       // 100 ns period

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic longint model_dist2(input pos_t a, input pos_t b);
		longint dx;
		longint dy;
		longint dz;
		dx = longint'(b.x) - longint'(a.x);
		dy = longint'(b.y) - longint'(a.y);
		dz = longint'(b.z) - longint'(a.z);
		return dx * dx + dy * dy + dz * dz;
	endfunction

	function automatic int pair_key(input particle_id_t r, input particle_id_t n);
		return int'({r, n});
	endfunction

	// Second slots of lanes 0 and 1 are spare
	function automatic bit slot_walked(input int s);
		return (s != 1) && (s != 3);
	endfunction

	function automatic logic signed [`POS_W-1:0] rand_coord(input int span);
		int v;
		v = int'($urandom_range(2 * span, 0)) - span;
		return `POS_W'(v);
	endfunction

	// Load, run and slack cycles of one case
	function automatic int case_bound(input int c);
		int sum;
		sum = 0;
		for (int s = 0; s < NUM_SLOTS; s++)
			sum += CASE_TAB[c][s];
		return sum * 20 + CASE_TAB[c][DELAY_COL] + 40;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_pair(input pair_t got, input pair_t expected);
		if (got !== expected)
			report_mismatch($sformatf("pair ref %0d:%0d nb %0d:%0d dist2 %0d, expected %0d",
				got.ref_id.slot, got.ref_id.addr, got.nb_id.slot, got.nb_id.addr,
				got.dist2, expected.dist2));
	endtask

	task automatic check_count(input int got, input int expected, input string what);
		if (got != expected)
			report_mismatch($sformatf("%s count %0d, expected %0d", what, got, expected));
	endtask

	task automatic check_done(input int got, input int expected, input string what);
		if (got != expected)
			report_mismatch($sformatf("%s saw %0d done pulses, expected %0d", what, got,
				expected));
	endtask

	// One pair from the DUT, judged against the model
	task automatic take_pair(input pair_t got);
		pair_t expected;
		string ids;
		int key;
		ids = $sformatf("ref %0d:%0d nb %0d:%0d", got.ref_id.slot, got.ref_id.addr,
			got.nb_id.slot, got.nb_id.addr);
		if (!collecting)
			report_mismatch({"pair outside a run, ", ids});
		if (done_seen != 0 || done)              // Done must trail the last pair
			report_mismatch({"pair at or after done, ", ids});
		if (got.nb_id.slot == 1 || got.nb_id.slot == 3)
			report_mismatch({"pair from a spare slot, ", ids});
		if (got.nb_id.slot == 0 && got.nb_id.addr <= got.ref_id.addr)
			report_mismatch({"home pair not above reference, ", ids});
		key = pair_key(got.ref_id, got.nb_id);
		if (!exp_set.exists(key))
			report_mismatch({"pair not in expected set, ", ids});
		if (seen_set.exists(key))
			report_mismatch({"duplicate pair, ", ids});
		seen_set[key] = 1'b1;
		pairs_seen++;
		expected.ref_id = got.ref_id;
		expected.nb_id = got.nb_id;
		expected.dist2 = `DIST2_W'(model_dist2(cell_pos[got.ref_id.slot][got.ref_id.addr],
			cell_pos[got.nb_id.slot][got.nb_id.addr]));
		check_pair(got, expected);
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (!rst && pair_valid)
			take_pair(pair);
		if (!rst && done)
			done_seen++;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic write_word(input int slot, input int addr, input cell_word_u w);
		load_en = 1'b1;
		load_slot = `SLOT_W'(slot);
		load_addr = `CELL_ADDR_W'(addr);
		load_word = w;
		tick();
	endtask

	// Count word first, then random positions inside the span
	task automatic load_case(input int c);
		cell_word_u w;
		pos_t p;
		int span;
		span = CASE_TAB[c][SPAN_COL];
		for (int s = 0; s < NUM_SLOTS; s++)
		begin
			w = '0;
			w.cnt.count = `CELL_ADDR_W'(CASE_TAB[c][s]);
			write_word(s, 0, w);
			for (int a = 1; a <= CASE_TAB[c][s]; a++)
			begin
				p.x = rand_coord(span);
				p.y = rand_coord(span);
				p.z = rand_coord(span);
				cell_pos[s][a] = p;
				w.pos = p;
				write_word(s, a, w);
			end
		end
		load_en = 1'b0;
	endtask

	// Half shell, every reference against walked slots
	task automatic build_expected(input int c);
		particle_id_t r_id;
		particle_id_t n_id;
		longint d;
		exp_set.delete();
		seen_set.delete();
		exp_total = 0;
		for (int r = 1; r <= CASE_TAB[c][0]; r++)
			for (int s = 0; s < NUM_SLOTS; s++)
				if (slot_walked(s))
					for (int a = 1; a <= CASE_TAB[c][s]; a++)
						if (s != 0 || a > r)     // Home pairs once, no self
						begin
							d = model_dist2(cell_pos[0][r], cell_pos[s][a]);
							if (d < `CUTOFF_2)
							begin
								r_id.slot = '0;
								r_id.addr = `CELL_ADDR_W'(r);
								n_id.slot = `SLOT_W'(s);
								n_id.addr = `CELL_ADDR_W'(a);
								exp_set[pair_key(r_id, n_id)] = 1'b1;
								exp_total++;
							end
						end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		load_en = 1'b0;
		load_slot = '0;
		load_addr = '0;
		load_word = '0;
		exp_total = 0;
		pairs_seen = 0;
		done_seen = 0;
		collecting = 1'b0;
		void'($urandom(9225));
		repeat (2) @(posedge clk);               // Two cycles of reset
		#DRIVE_DELAY;
		rst = 1'b0;
		for (int c = 0; c < NUM_CASES; c++)
		begin
			collecting = 1'b0;
			load_case(c);
			build_expected(c);
			repeat (CASE_TAB[c][DELAY_COL]) tick();
			pairs_seen = 0;
			done_seen = 0;
			collecting = 1'b1;
			start = 1'b1;
			tick();
			start = 1'b0;
			while (done_seen == 0)
				tick();
			repeat (TAIL_CYCLES) tick();         // Late pairs or a second done
			check_done(done_seen, 1, $sformatf("case %0d", c));
			check_count(pairs_seen, exp_total, $sformatf("case %0d pairs", c));
			$display("Case %0d done with %0d pairs", c, pairs_seen);
		end
		$display("** PASS **");
		$finish;
	end

	// Watchdog over all case bounds
	initial
	begin
		int limit;
		limit = 20;
		for (int c = 0; c < NUM_CASES; c++)
			limit += case_bound(c);
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("** FAIL **");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
+incdir+bench
common/md_pkg.sv
source/cell_memory.sv
source/ref_sequencer.sv
neighbor_lane/pair_fifo.sv
neighbor_lane/neighbor_lane.sv
source/pair_arbiter.sv
source/pair_gen_top.sv
bench/pair_gen_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pair generator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module pair_gen_tb -f project.f

# Exit status of the run is decided by the log below
./obj_dir/Vpair_gen_tb | tee sim.log

if grep -q -F -x '** PASS **' sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
